// File: source/icacheDefs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// Cache geometry
`define WAYS 4
`define SETS 16
`define LINE_BITS 128

// Address split: tag | index | byte offset
`define OFFSET_W 4
`define INDEX_W 4
`define TAG_W 24

// Legal fetch range, inclusive
`define LEGAL_LO 32'h0000_0000
`define LEGAL_HI 32'h0000_FFFF

`endif

// File: source/fetchPkg.sv
`default_nettype none

`include "icacheDefs.svh"

package fetchPkg;

    // Packet field widths
    localparam int ID_W = 4;
    localparam int LINE_PC_W = 32 - `OFFSET_W;

    // Fault status of an output packet
    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_ACCESS
    } fetchFault_e;

    typedef logic [ID_W-1:0] fetchId_t;

    // pc bits 31 down to the line offset
    typedef logic [LINE_PC_W-1:0] linePc_t;

endpackage

`default_nettype wire

// File: source/memPkg.sv
`default_nettype none

`include "icacheDefs.svh"

package memPkg;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_REQ,
        RF_WRITE
    } refillState_e;

    typedef logic [`LINE_BITS-1:0] line_t;

endpackage

`default_nettype wire

// File: source/fetchStage.sv
`default_nettype none

`include "icacheDefs.svh"

module fetchStage import fetchPkg::*; (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input logic [31:0] fetchPc,
    input logic mispredict,
    input fetchId_t misprId,
    input logic miss,
    input logic pktValid,
    input logic refillBusy,
    input logic nearFull,
    output logic stall,
    output logic rdEn,
    output logic [`INDEX_W-1:0] rdIndex,
    output logic pipeValid,
    output logic [31:0] pipePc,
    output fetchId_t curId
);

    logic started;
    logic accept;

    // Held off for one cycle after reset, during refill and on a full buffer
    assign stall = !started || refillBusy || nearFull;
    assign accept = fetchValid && !stall;

    // Ways are read in the acceptance cycle
    assign rdEn = accept;
    assign rdIndex = fetchPc[`OFFSET_W +: `INDEX_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            pipeValid <= 1'b0;
        end else begin
            started <= 1'b1;
            if (mispredict || miss) begin
                pipeValid <= 1'b0;
            end else begin
                pipeValid <= accept;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pipePc <= fetchPc;
        end
    end

    // Fetch id counter
    always_ff @(posedge clk) begin
        if (rst) begin
            curId <= '0;
        end else if (mispredict) begin
            curId <= misprId + fetchId_t'(1);
        end else if (pktValid) begin
            curId <= curId + fetchId_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: source/cacheWay.sv
`default_nettype none

`include "icacheDefs.svh"

module cacheWay import memPkg::*; (
    input logic clk,
    input logic rst,
    input logic rdEn,
    input logic [`INDEX_W-1:0] rdIndex,
    input logic [`TAG_W-1:0] lookupTag,
    input logic wrEn,
    input logic [`INDEX_W-1:0] wrIndex,
    input logic [`TAG_W-1:0] wrTag,
    input line_t wrData,
    output logic wayHit,
    output line_t wayData
);

    logic [`SETS-1:0] validBits;
    logic [`TAG_W-1:0] tagMem [`SETS];
    line_t dataMem [`SETS];

    logic rdValid;
    logic [`TAG_W-1:0] rdTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            rdValid <= 1'b0;
        end else begin
            if (wrEn) begin
                validBits[wrIndex] <= 1'b1;
            end
            if (rdEn) begin
                rdValid <= validBits[rdIndex];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            tagMem[wrIndex] <= wrTag;
            dataMem[wrIndex] <= wrData;
        end
        if (rdEn) begin
            rdTag <= tagMem[rdIndex];
            wayData <= dataMem[rdIndex];
        end
    end

    // Tag of the op now in the pipeline register
    assign wayHit = rdValid && (rdTag == lookupTag);

endmodule

`default_nettype wire

// File: source/hitSelect.sv
`default_nettype none

`include "icacheDefs.svh"

module hitSelect import fetchPkg::*, memPkg::*; (
    input logic clk,
    input logic rst,
    input logic pipeValid,
    input logic [31:0] pipePc,
    input fetchId_t curId,
    input logic [`WAYS-1:0] wayHit,
    input line_t wayData [`WAYS],
    output logic pktValid,
    output linePc_t pktPc,
    output fetchFault_e pktFault,
    output line_t pktData,
    output fetchId_t pktId,
    output logic miss,
    output logic [31:0] missPc
);

    logic inRange;
    logic hitAny;
    line_t hitData;

    // One unsigned compare covers both bounds
    assign inRange = (pipePc - `LEGAL_LO) <= (`LEGAL_HI - `LEGAL_LO);
    assign hitAny = |wayHit;

    always_comb begin
        hitData = '0;
        for (int w = 0; w < `WAYS; w++) begin
            if (wayHit[w]) begin
                hitData = wayData[w];
            end
        end
    end

    // Range check wins over the tag result
    assign pktValid = pipeValid && (!inRange || hitAny);
    assign pktPc = pipePc[31:`OFFSET_W];
    assign pktFault = inRange ? FAULT_NONE : FAULT_ACCESS;
    assign pktData = inRange ? hitData : '0;
    assign pktId = curId;

    assign miss = pipeValid && inRange && !hitAny;
    assign missPc = pipePc;

    // A line is never resident in two ways
    onehotHit: assert property (@(posedge clk) disable iff (rst)
        pipeValid |-> $onehot0(wayHit));

endmodule

`default_nettype wire

// File: source/missHandler.sv
`default_nettype none

`include "icacheDefs.svh"

module missHandler import memPkg::*; (
    input logic clk,
    input logic rst,
    input logic miss,
    input logic [31:0] missPc,
    input logic mispredict,
    input logic memAck,
    input line_t memData,
    output logic memReq,
    output logic [31:0] memAddr,
    output logic refillBusy,
    output logic [`WAYS-1:0] wrEn,
    output logic [`INDEX_W-1:0] wrIndex,
    output logic [`TAG_W-1:0] wrTag,
    output line_t wrData
);

    localparam int VIC_W = $clog2(`WAYS);

    refillState_e state;
    logic [VIC_W-1:0] victim;
    logic [31:0] reqAddr;
    line_t lineBuf;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RF_IDLE;
            victim <= '0;
        end else begin
            case (state)
                RF_IDLE: if (miss && !mispredict) state <= RF_REQ;
                RF_REQ: if (memAck) state <= RF_WRITE;
                RF_WRITE: begin
                    state <= RF_IDLE;
                    victim <= victim + VIC_W'(1);
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_IDLE && miss) begin
            reqAddr <= {missPc[31:`OFFSET_W], {`OFFSET_W{1'b0}}};
        end
        if (memAck) begin
            lineBuf <= memData;
        end
    end

    assign memReq = (state == RF_REQ);
    assign memAddr = reqAddr;
    assign refillBusy = (state != RF_IDLE);

    always_comb begin
        wrEn = '0;
        if (state == RF_WRITE) begin
            wrEn[victim] = 1'b1;
        end
    end

    assign wrIndex = reqAddr[`OFFSET_W +: `INDEX_W];
    assign wrTag = reqAddr[31 -: `TAG_W];
    assign wrData = lineBuf;

    reqStable: assert property (@(posedge clk) disable iff (rst)
        memReq && !memAck |=> memReq && $stable(memAddr));

    // Fetch stage must hold off lookups during a refill
    noMissBusy: assert property (@(posedge clk) disable iff (rst)
        refillBusy |-> !miss);

endmodule

`default_nettype wire

// File: source/instrBuffer.sv
`default_nettype none

`include "icacheDefs.svh"

module instrBuffer import fetchPkg::*, memPkg::*; (
    input logic clk,
    input logic rst,
    input logic mispredict,
    input logic inValid,
    input linePc_t inPc,
    input fetchFault_e inFault,
    input line_t inData,
    input fetchId_t inId,
    input logic outReady,
    output logic outValid,
    output linePc_t outPc,
    output fetchFault_e outFault,
    output line_t outData,
    output fetchId_t outId,
    output logic nearFull
);

    localparam int DEPTH = 4;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    linePc_t pcMem [DEPTH];
    fetchFault_e faultMem [DEPTH];
    line_t dataMem [DEPTH];
    fetchId_t idMem [DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic load;

    // Head register refills when empty or being consumed
    assign load = (count != '0) && (!outValid || outReady);
    assign nearFull = count >= CNT_W'(2);

    always_ff @(posedge clk) begin
        if (rst || mispredict) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            outValid <= 1'b0;
        end else begin
            if (inValid) wrPtr <= wrPtr + PTR_W'(1);
            if (load) rdPtr <= rdPtr + PTR_W'(1);
            case ({inValid, load})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: ;
            endcase
            if (load) begin
                outValid <= 1'b1;
            end else if (outReady) begin
                outValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            pcMem[wrPtr] <= inPc;
            faultMem[wrPtr] <= inFault;
            dataMem[wrPtr] <= inData;
            idMem[wrPtr] <= inId;
        end
        if (load) begin
            outPc <= pcMem[rdPtr];
            outFault <= faultMem[rdPtr];
            outData <= dataMem[rdPtr];
            outId <= idMem[rdPtr];
        end
    end

    // Stall threshold leaves room for the op in flight
    noOverflow: assert property (@(posedge clk) disable iff (rst)
        inValid |-> count != CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: source/icacheTop.sv
`default_nettype none

`include "icacheDefs.svh"

module icacheTop import fetchPkg::*, memPkg::*; (
    input logic clk,
    input logic rst,
    input logic fetchValid,
    input logic [31:0] fetchPc,
    output logic stall,
    input logic mispredict,
    input fetchId_t misprId,
    output logic missValid,
    output logic [31:0] missPc,
    output logic memReq,
    output logic [31:0] memAddr,
    input logic memAck,
    input line_t memData,
    input logic outReady,
    output logic outValid,
    output linePc_t outPc,
    output fetchFault_e outFault,
    output line_t outData,
    output fetchId_t outId
);

    logic rdEn;
    logic [`INDEX_W-1:0] rdIndex;
    logic pipeValid;
    logic [31:0] pipePc;
    fetchId_t curId;
    logic nearFull;
    logic refillBusy;

    logic [`WAYS-1:0] wayHit;
    line_t wayData [`WAYS];
    logic [`WAYS-1:0] wrEn;
    logic [`INDEX_W-1:0] wrIndex;
    logic [`TAG_W-1:0] wrTag;
    line_t wrData;

    logic pktValid;
    linePc_t pktPc;
    fetchFault_e pktFault;
    line_t pktData;
    fetchId_t pktId;

    fetchStage fetchStage_i (
        .clk(clk), .rst(rst),
        .fetchValid(fetchValid), .fetchPc(fetchPc),
        .mispredict(mispredict), .misprId(misprId),
        .miss(missValid), .pktValid(pktValid),
        .refillBusy(refillBusy), .nearFull(nearFull),
        .stall(stall), .rdEn(rdEn), .rdIndex(rdIndex),
        .pipeValid(pipeValid), .pipePc(pipePc), .curId(curId)
    );

    for (genvar w = 0; w < `WAYS; w++) begin : gWay
        cacheWay way_i (
            .clk(clk), .rst(rst),
            .rdEn(rdEn), .rdIndex(rdIndex),
            .lookupTag(pipePc[31 -: `TAG_W]),
            .wrEn(wrEn[w]), .wrIndex(wrIndex), .wrTag(wrTag), .wrData(wrData),
            .wayHit(wayHit[w]), .wayData(wayData[w])
        );
    end

    hitSelect hitSelect_i (
        .clk(clk), .rst(rst),
        .pipeValid(pipeValid), .pipePc(pipePc), .curId(curId),
        .wayHit(wayHit), .wayData(wayData),
        .pktValid(pktValid), .pktPc(pktPc), .pktFault(pktFault),
        .pktData(pktData), .pktId(pktId),
        .miss(missValid), .missPc(missPc)
    );

    missHandler missHandler_i (
        .clk(clk), .rst(rst),
        .miss(missValid), .missPc(missPc), .mispredict(mispredict),
        .memAck(memAck), .memData(memData),
        .memReq(memReq), .memAddr(memAddr), .refillBusy(refillBusy),
        .wrEn(wrEn), .wrIndex(wrIndex), .wrTag(wrTag), .wrData(wrData)
    );

    instrBuffer instrBuffer_i (
        .clk(clk), .rst(rst), .mispredict(mispredict),
        .inValid(pktValid), .inPc(pktPc), .inFault(pktFault),
        .inData(pktData), .inId(pktId),
        .outReady(outReady), .outValid(outValid), .outPc(outPc),
        .outFault(outFault), .outData(outData), .outId(outId),
        .nearFull(nearFull)
    );

endmodule

`default_nettype wire

// File: testbench/icacheTb.sv
`default_nettype none

`include "icacheDefs.svh"

module icacheTb import fetchPkg::*, memPkg::*; ();

    localparam int PERIOD = 40;
    // Roughly 130 refills of up to 14 cycles each, plus hit traffic and back-pressure
    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic rst;
    logic fetchValid;
    logic [31:0] fetchPc;
    logic stall;
    logic mispredict;
    fetchId_t misprId;
    logic missValid;
    logic [31:0] missPc;
    logic memReq;
    logic [31:0] memAddr;
    logic memAck;
    line_t memData;
    logic outReady;
    logic outValid;
    linePc_t outPc;
    fetchFault_e outFault;
    line_t outData;
    fetchId_t outId;

    int seed = 41894;
    int errors = 0;
    int checks = 0;
    int missCount = 0;
    int reqCount = 0;
    int cycleCount = 0;
    // 0 always ready, 1 random, 2 held low
    int readyMode = 0;
    logic [31:0] lastMissLine;
    fetchId_t expId;

    linePc_t expPc [$];
    fetchFault_e expFault [$];
    line_t expData [$];
    fetchId_t expIdQ [$];

    // Expected tag contents, following the round-robin victim rule
    logic [`TAG_W-1:0] refTag [`SETS][`WAYS];
    logic refValid [`SETS][`WAYS];
    int refVictim;

    icacheTop dut_i (
        .clk(clk), .rst(rst),
        .fetchValid(fetchValid), .fetchPc(fetchPc), .stall(stall),
        .mispredict(mispredict), .misprId(misprId),
        .missValid(missValid), .missPc(missPc),
        .memReq(memReq), .memAddr(memAddr), .memAck(memAck), .memData(memData),
        .outReady(outReady), .outValid(outValid), .outPc(outPc),
        .outFault(outFault), .outData(outData), .outId(outId)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic line_t lineOf(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:`OFFSET_W], {`OFFSET_W{1'b0}}};
        return {a ^ 32'hC3A5_0F1E, ~a + 32'd17, {a[15:0], a[31:16]} ^ 32'h5A5A_5A5A,
            a * 32'h0001_0007};
    endfunction

    function automatic logic inRange(input logic [31:0] addr);
        longint a;
        a = longint'(addr);
        return (a >= longint'(`LEGAL_LO)) && (a <= longint'(`LEGAL_HI));
    endfunction

    function automatic logic [31:0] addrOf(input int tag, input int set);
        return (32'(tag) << (`OFFSET_W + `INDEX_W)) | (32'(set) << `OFFSET_W);
    endfunction

    function automatic logic predictMiss(input logic [31:0] pc);
        logic [`INDEX_W-1:0] idx;
        logic hit;
        idx = pc[`OFFSET_W +: `INDEX_W];
        hit = 1'b0;
        for (int w = 0; w < `WAYS; w++) begin
            if (refValid[idx][w] && refTag[idx][w] == pc[31 -: `TAG_W]) begin
                hit = 1'b1;
            end
        end
        return inRange(pc) && !hit;
    endfunction

    task automatic recordRefill(input logic [31:0] pc);
        logic [`INDEX_W-1:0] idx;
        idx = pc[`OFFSET_W +: `INDEX_W];
        refTag[idx][refVictim] = pc[31 -: `TAG_W];
        refValid[idx][refVictim] = 1'b1;
        refVictim = (refVictim + 1) % `WAYS;
    endtask

    task automatic pushExpected(input logic [31:0] pc);
        expPc.push_back(pc[31:`OFFSET_W]);
        if (inRange(pc)) begin
            expFault.push_back(FAULT_NONE);
            expData.push_back(lineOf(pc));
        end else begin
            expFault.push_back(FAULT_ACCESS);
            expData.push_back(line_t'(0));
        end
        expIdQ.push_back(expId);
        expId = expId + fetchId_t'(1);
    endtask

    // Returns at the falling edge after acceptance, with the op in the pipeline
    task automatic issueOp(input logic [31:0] pc);
        @(negedge clk);
        fetchValid = 1'b1;
        fetchPc = pc;
        while (stall) begin
            @(negedge clk);
        end
        @(negedge clk);
        fetchValid = 1'b0;
    endtask

    // Missed pcs are issued again once the refill is done
    task automatic fetchLine(input logic [31:0] pc);
        logic expMiss;
        logic done;
        done = 1'b0;
        while (!done) begin
            expMiss = predictMiss(pc);
            issueOp(pc);
            checks++;
            assert (missValid == expMiss) else begin
                $display("Mismatch missValid: got %h expected %h (pc %h)",
                    missValid, expMiss, pc);
                errors++;
            end
            if (missValid) begin
                assert (missPc == pc) else begin
                    $display("Mismatch missPc: got %h expected %h", missPc, pc);
                    errors++;
                end
                missCount++;
                lastMissLine = {pc[31:`OFFSET_W], {`OFFSET_W{1'b0}}};
                recordRefill(pc);
            end else begin
                pushExpected(pc);
                done = 1'b1;
            end
        end
    endtask

    // Lands in the pipeline cycle of the last op, with a wrong-path op offered alongside
    task automatic flushMispredict(input fetchId_t id, input logic [31:0] wrongPc);
        readyMode = 2;
        mispredict = 1'b1;
        misprId = id;
        fetchValid = 1'b1;
        fetchPc = wrongPc;
        expPc.delete();
        expFault.delete();
        expData.delete();
        expIdQ.delete();
        expId = id + fetchId_t'(1);
        @(negedge clk);
        mispredict = 1'b0;
        fetchValid = 1'b0;
        readyMode = 0;
    endtask

    task automatic checkCount(input string what, input int got, input int want);
        checks++;
        assert (got == want) else begin
            $display("Mismatch %s: got %h expected %h", what, got, want);
            errors++;
        end
    endtask

    task automatic finishTest(input int num, input string name, input int errStart);
        while (expPc.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        $display("Test %0d %s: %0d errors", num, name, errors - errStart);
    endtask

    // Packet compare, also owns outReady
    initial begin
        forever begin
            @(negedge clk);
            case (readyMode)
                0: outReady = 1'b1;
                1: outReady = ($random(seed) & 3) == 0;
                default: outReady = 1'b0;
            endcase
            if (!rst && outValid && outReady) begin
                checks++;
                assert (expPc.size() != 0) else begin
                    $display("Output packet with id %h arrived when none was expected", outId);
                    errors++;
                end
                if (expPc.size() != 0) begin
                    assert (outPc == expPc[0]) else begin
                        $display("Mismatch outPc: got %h expected %h", outPc, expPc[0]);
                        errors++;
                    end
                    assert (outFault == expFault[0]) else begin
                        $display("Mismatch outFault: got %h expected %h", outFault, expFault[0]);
                        errors++;
                    end
                    assert (outData == expData[0]) else begin
                        $display("Mismatch outData: got %h expected %h", outData, expData[0]);
                        errors++;
                    end
                    assert (outId == expIdQ[0]) else begin
                        $display("Mismatch outId: got %h expected %h", outId, expIdQ[0]);
                        errors++;
                    end
                    void'(expPc.pop_front());
                    void'(expFault.pop_front());
                    void'(expData.pop_front());
                    void'(expIdQ.pop_front());
                end
            end
        end
    end

    // External memory with a random answer delay of 1 to 6 cycles
    initial begin : memModel
        int delay;
        forever begin
            @(negedge clk);
            if (memReq) begin
                reqCount++;
                checks++;
                assert (memAddr == lastMissLine) else begin
                    $display("Mismatch memAddr: got %h expected %h", memAddr, lastMissLine);
                    errors++;
                end
                delay = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay - 1) @(negedge clk);
                memAck = 1'b1;
                memData = lineOf(memAddr);
                @(negedge clk);
                memAck = 1'b0;
            end
        end
    end

    initial begin
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int errStart;
        int missStart;
        int reqStart;
        int evictTags [11];
        logic [31:0] pc;
        fetchValid = 1'b0;
        fetchPc = '0;
        mispredict = 1'b0;
        misprId = '0;
        memAck = 1'b0;
        memData = '0;
        outReady = 1'b0;
        lastMissLine = '0;
        expId = '0;
        refVictim = 0;
        for (int s = 0; s < `SETS; s++) begin
            for (int w = 0; w < `WAYS; w++) begin
                refValid[s][w] = 1'b0;
                refTag[s][w] = '0;
            end
        end
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        errStart = errors;
        missStart = missCount;
        // Stall holds for the first cycle out of reset only
        checkCount("stall", stall, 1);
        checkCount("outValid", outValid, 0);
        checkCount("missValid", missValid, 0);
        checkCount("memReq", memReq, 0);
        @(negedge clk);
        checkCount("stall", stall, 0);
        for (int i = 0; i < 4; i++) begin
            fetchLine(32'h0000_0100 + 32'(i * 20));
        end
        checkCount("missCount", missCount - missStart, 4);
        finishTest(1, "cold fetch", errStart);

        // Set-major order spreads each set over all four ways
        errStart = errors;
        missStart = missCount;
        for (int s = 0; s < `SETS; s++) begin
            for (int k = 0; k < `WAYS; k++) begin
                fetchLine(addrOf(8'h10 + k, s));
            end
        end
        checkCount("missCount", missCount - missStart, 64);
        missStart = missCount;
        for (int s = 0; s < `SETS; s++) begin
            for (int k = 0; k < `WAYS; k++) begin
                fetchLine(addrOf(8'h10 + k, s) + 32'(4 * k));
            end
        end
        checkCount("missCount", missCount - missStart, 0);
        finishTest(2, "resident lines", errStart);

        // Victim pointer is back at way 0, which holds tag 0x10 in set 5
        errStart = errors;
        missStart = missCount;
        evictTags = '{'h14, 'h11, 'h12, 'h13, 'h14, 'h10, 'h12, 'h13, 'h14, 'h10, 'h11};
        foreach (evictTags[i]) begin
            fetchLine(addrOf(evictTags[i], 5));
        end
        checkCount("missCount", missCount - missStart, 3);
        finishTest(3, "round-robin eviction", errStart);

        errStart = errors;
        missStart = missCount;
        reqStart = reqCount;
        fetchLine(32'h0001_0000);
        fetchLine(32'h0001_0010);
        fetchLine(32'h8000_1234);
        fetchLine(32'hFFFF_FFF0);
        finishTest(4, "access fault", errStart);
        checkCount("missCount", missCount - missStart, 0);
        checkCount("reqCount", reqCount - reqStart, 0);

        errStart = errors;
        readyMode = 1;
        for (int i = 0; i < 32; i++) begin
            pc = addrOf(8'h10 + int'($unsigned($random(seed)) % 8),
                int'($unsigned($random(seed)) % `SETS));
            pc = pc | (32'($random(seed)) & 32'h0000_000C);
            if ($unsigned($random(seed)) % 8 == 0) begin
                pc = pc | 32'h0004_0000;
            end
            fetchLine(pc);
        end
        finishTest(5, "back-pressure", errStart);
        readyMode = 0;

        errStart = errors;
        readyMode = 2;
        fetchLine(addrOf(8'h12, 0));
        fetchLine(addrOf(8'h13, 1));
        fetchLine(addrOf(8'h12, 2));
        flushMispredict(4'hA, addrOf(8'h11, 9));
        fetchLine(addrOf(8'h10, 7));
        fetchLine(addrOf(8'h11, 8));
        finishTest(6, "mispredict", errStart);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/fetchPkg.sv
source/memPkg.sv
source/fetchStage.sv
source/cacheWay.sv
source/hitSelect.sv
source/missHandler.sv
source/instrBuffer.sv
source/icacheTop.sv
testbench/icacheTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module icacheTb -o icacheSim &&
./obj_dir/icacheSim | tee /dev/stderr | grep -Fxq "Done: no errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }
